// ==== logic/bp_wb_pkg.sv ====
// Shared definitions for the memory-command to Wishbone bridge
// Widths, command encodings, the read-data word view and the
// fixed boot configuration table played out by the loader
`default_nettype none

package bp_wb_pkg;

   // Physical byte address and data word
   localparam int paddr_width_lp = 40;
   localparam int dword_width_lp = 64;

   // Wishbone side addresses whole dwords, bits 39:3
   localparam int wb_adr_width_lp = paddr_width_lp - 3;
   localparam int wb_sel_width_lp = dword_width_lp / 8;

   // Boot writes issued before the external port opens
   localparam int cfg_entries_lp = 4;

   // Command and response type
   typedef enum logic [0:0]
   {
      e_mem_rd = 1'b0,
      e_mem_wr = 1'b1
   } bp_mem_msg_e;

   // Access size, log2 of the byte count
   typedef enum logic [1:0]
   {
      e_size_1 = 2'b00,
      e_size_2 = 2'b01,
      e_size_4 = 2'b10,
      e_size_8 = 2'b11
   } bp_mem_size_e;

   // Whole dword for 8-byte reads, byte lanes for narrow extraction
   typedef union packed
   {
      logic [dword_width_lp-1:0] dword;
      logic [wb_sel_width_lp-1:0][7:0] bytes;
   } bp_dword_u;

   // Config window at 0x00_0020_0000, one dword per register
   localparam logic [paddr_width_lp-1:0] cfg_addr_table_lp [cfg_entries_lp] = '{
      40'h00_0020_0000,
      40'h00_0020_0008,
      40'h00_0020_0010,
      40'h00_0020_0018
   };

   // Core id, DRAM base, host base, freeze release last
   localparam logic [dword_width_lp-1:0] cfg_data_table_lp [cfg_entries_lp] = '{
      64'h0000_0000_0000_0001,
      64'h0000_0000_8000_0000,
      64'h0000_0000_0010_0000,
      64'h0000_0000_0000_0000
   };

endpackage

`default_nettype wire

// ==== logic/bp_wb_cmd_decode.sv ====
// Command decode stage
// Holds one memory command and turns it into a Wishbone dword
// address, byte select and lane-replicated write data
`default_nettype none

module bp_wb_cmd_decode
(
   input  wire                                    clk_i,
   input  wire                                    rst_i,
   input  bp_wb_pkg::bp_mem_msg_e                 cmd_type_i,
   input  bp_wb_pkg::bp_mem_size_e                cmd_size_i,
   input  wire [bp_wb_pkg::paddr_width_lp-1:0]    cmd_addr_i,
   input  wire [bp_wb_pkg::dword_width_lp-1:0]    cmd_data_i,
   input  wire                                    cmd_v_i,
   output logic                                   cmd_ready_o,
   input  wire                                    dec_ready_i,
   output logic                                   dec_v_o,
   output logic                                   dec_we_o,
   output logic [bp_wb_pkg::wb_adr_width_lp-1:0]  dec_adr_o,
   output logic [bp_wb_pkg::wb_sel_width_lp-1:0]  dec_sel_o,
   output logic [bp_wb_pkg::dword_width_lp-1:0]   dec_dat_o,
   output bp_wb_pkg::bp_mem_size_e                dec_size_o,
   output logic [2:0]                             dec_offset_o
);
   import bp_wb_pkg::*;

   logic [wb_sel_width_lp-1:0] size_mask;
   logic [dword_width_lp-1:0]  rep_data;
   logic                       dec_v_q;

   // Run of ones, one per byte of the access
   // Data copied into every lane of that size
   always_comb
   begin
      case (cmd_size_i)
         e_size_1:
         begin
            size_mask = 8'h01;
            rep_data  = {8{cmd_data_i[7:0]}};
         end
         e_size_2:
         begin
            size_mask = 8'h03;
            rep_data  = {4{cmd_data_i[15:0]}};
         end
         e_size_4:
         begin
            size_mask = 8'h0f;
            rep_data  = {2{cmd_data_i[31:0]}};
         end
         default:
         begin
            size_mask = 8'hff;
            rep_data  = cmd_data_i;
         end
      endcase
   end

   // Empty slot, or the held entry leaves this cycle
   assign cmd_ready_o = ~dec_v_q | dec_ready_i;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         dec_v_q <= 1'b0;
      else if (cmd_ready_o)
         dec_v_q <= cmd_v_i;
   end

   // Decoded fields load only on a transfer
   always_ff @(posedge clk_i)
   begin
      if (cmd_v_i && cmd_ready_o)
      begin
         dec_we_o     <= (cmd_type_i == e_mem_wr);
         dec_adr_o    <= cmd_addr_i[paddr_width_lp-1:3];
         // Lanes above the word end drop off
         dec_sel_o    <= size_mask << cmd_addr_i[2:0];
         dec_dat_o    <= rep_data;
         dec_size_o   <= cmd_size_i;
         dec_offset_o <= cmd_addr_i[2:0];
      end
   end

   assign dec_v_o = dec_v_q;

endmodule

`default_nettype wire

// ==== logic/bp_wb_cycle_exec.sv ====
// Wishbone cycle execute stage
// Runs one classic cycle per decoded command, idle or in cycle,
// and hands the read word and error flag on to the result stage
`default_nettype none

module bp_wb_cycle_exec
(
   input  wire                                    clk_i,
   input  wire                                    rst_i,
   input  wire                                    dec_v_i,
   input  wire                                    dec_we_i,
   input  wire [bp_wb_pkg::wb_adr_width_lp-1:0]   dec_adr_i,
   input  wire [bp_wb_pkg::wb_sel_width_lp-1:0]   dec_sel_i,
   input  wire [bp_wb_pkg::dword_width_lp-1:0]    dec_dat_i,
   input  bp_wb_pkg::bp_mem_size_e                dec_size_i,
   input  wire [2:0]                              dec_offset_i,
   output logic                                   dec_ready_o,
   input  wire                                    res_busy_i,
   output logic [bp_wb_pkg::wb_adr_width_lp-1:0]  wb_adr_o,
   output logic [bp_wb_pkg::dword_width_lp-1:0]   wb_dat_o,
   output logic [bp_wb_pkg::wb_sel_width_lp-1:0]  wb_sel_o,
   output logic                                   wb_we_o,
   output logic                                   wb_cyc_o,
   output logic                                   wb_stb_o,
   input  wire [bp_wb_pkg::dword_width_lp-1:0]    wb_dat_i,
   input  wire                                    wb_ack_i,
   input  wire                                    wb_err_i,
   output logic                                   exec_v_o,
   output logic                                   exec_we_o,
   output logic                                   exec_err_o,
   output bp_wb_pkg::bp_dword_u                   exec_dat_o,
   output bp_wb_pkg::bp_mem_size_e                exec_size_o,
   output logic [2:0]                             exec_offset_o
);
   logic in_cycle_q;
   logic exec_v_q;
   logic accept;
   logic done;

   // Hold off while a cycle runs or a result is still queued
   assign dec_ready_o = ~in_cycle_q & ~exec_v_q & ~res_busy_i;
   assign accept      = dec_v_i & dec_ready_o;
   // Slave ends the cycle with either ack or err
   assign done        = in_cycle_q & (wb_ack_i | wb_err_i);

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         in_cycle_q <= 1'b0;
         exec_v_q   <= 1'b0;
      end
      else
      begin
         // One-cycle pulse toward the result stage
         exec_v_q <= done;
         if (accept)
            in_cycle_q <= 1'b1;
         else if (done)
            in_cycle_q <= 1'b0;
      end
   end

   // Bus fields latched for the whole cycle
   always_ff @(posedge clk_i)
   begin
      if (accept)
      begin
         wb_adr_o      <= dec_adr_i;
         wb_dat_o      <= dec_dat_i;
         wb_sel_o      <= dec_sel_i;
         wb_we_o       <= dec_we_i;
         exec_we_o     <= dec_we_i;
         exec_size_o   <= dec_size_i;
         exec_offset_o <= dec_offset_i;
      end
   end

   // Read word and status sampled at the terminating edge
   always_ff @(posedge clk_i)
   begin
      if (done)
      begin
         exec_dat_o.dword <= wb_dat_i;
         exec_err_o       <= wb_err_i;
      end
   end

   // Classic cycle, strobe tracks cycle
   assign wb_cyc_o = in_cycle_q;
   assign wb_stb_o = in_cycle_q;
   assign exec_v_o = exec_v_q;

endmodule

`default_nettype wire

// ==== logic/bp_wb_resp_result.sv ====
// Response result stage
// Pulls the addressed bytes down to lane 0, zero-extends them
// and holds the response until the consumer takes it
`default_nettype none

module bp_wb_resp_result
(
   input  wire                                    clk_i,
   input  wire                                    rst_i,
   input  wire                                    exec_v_i,
   input  wire                                    exec_we_i,
   input  wire                                    exec_err_i,
   input  bp_wb_pkg::bp_dword_u                   exec_dat_i,
   input  bp_wb_pkg::bp_mem_size_e                exec_size_i,
   input  wire [2:0]                              exec_offset_i,
   output logic                                   res_busy_o,
   output logic                                   resp_v_o,
   output bp_wb_pkg::bp_mem_msg_e                 resp_type_o,
   output logic [bp_wb_pkg::dword_width_lp-1:0]   resp_data_o,
   output logic                                   resp_err_o,
   input  wire                                    resp_yumi_i
);
   import bp_wb_pkg::*;

   bp_dword_u   shifted;
   bp_dword_u   rd_data;
   logic [3:0]  nbytes;
   logic        resp_v_q;

   assign nbytes = 4'd1 << exec_size_i;

   always_comb
   begin
      shifted.dword = exec_dat_i.dword >> {exec_offset_i, 3'b000};
      rd_data       = shifted;
      // Whole word as is for 8 bytes
      if (exec_size_i != e_size_8)
      begin
         // Clear lanes above the access
         for (int i = 0; i < wb_sel_width_lp; i++)
         begin
            if (i >= int'(nbytes))
               rd_data.bytes[i] = 8'h00;
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         resp_v_q <= 1'b0;
      else if (exec_v_i)
         resp_v_q <= 1'b1;
      else if (resp_yumi_i)
         resp_v_q <= 1'b0;
   end

   // Payload of the held response
   always_ff @(posedge clk_i)
   begin
      if (exec_v_i)
      begin
         resp_type_o <= exec_we_i ? e_mem_wr : e_mem_rd;
         resp_err_o  <= exec_err_i;
         // No data on writes or bus errors
         if (exec_we_i || exec_err_i)
            resp_data_o <= '0;
         else
            resp_data_o <= rd_data.dword;
      end
   end

   assign resp_v_o   = resp_v_q;
   assign res_busy_o = resp_v_q;

endmodule

`default_nettype wire

// ==== logic/bp_wb_cfg_loader.sv ====
// Boot configuration loader
// Walks the package table, one 8-byte write at a time, waits for
// each response and raises done once the last one is consumed
`default_nettype none

module bp_wb_cfg_loader
(
   input  wire                                    clk_i,
   input  wire                                    rst_i,
   output logic                                   cmd_v_o,
   output logic [bp_wb_pkg::paddr_width_lp-1:0]   cmd_addr_o,
   output logic [bp_wb_pkg::dword_width_lp-1:0]   cmd_data_o,
   input  wire                                    cmd_ready_i,
   input  wire                                    resp_v_i,
   output logic                                   resp_yumi_o,
   output logic                                   done_o
);
   import bp_wb_pkg::*;

   logic [$clog2(cfg_entries_lp)-1:0] idx_q;
   logic                              sent_q;
   logic                              done_q;
   logic                              last;

   assign last = (idx_q == $bits(idx_q)'(cfg_entries_lp - 1));

   // Offer a write only when nothing is outstanding
   assign cmd_v_o     = ~done_q & ~sent_q;
   assign cmd_addr_o  = cfg_addr_table_lp[idx_q];
   assign cmd_data_o  = cfg_data_table_lp[idx_q];
   assign resp_yumi_o = sent_q & resp_v_i;
   assign done_o      = done_q;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         idx_q  <= '0;
         sent_q <= 1'b0;
         done_q <= 1'b0;
      end
      else if (cmd_v_o && cmd_ready_i)
         sent_q <= 1'b1;
      else if (resp_yumi_o)
      begin
         sent_q <= 1'b0;
         // Sticky until the next reset
         if (last)
            done_q <= 1'b1;
         else
            idx_q <= idx_q + 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== logic/bp_wb_system_top.sv ====
// Memory-command to Wishbone bridge top level
// Loader owns the bridge until its done flag, then the external
// command and response ports take over for good
`default_nettype none

module bp_wb_system_top
(
   input  wire                                    clk_i,
   input  wire                                    rst_i,
   input  bp_wb_pkg::bp_mem_msg_e                 mem_cmd_type_i,
   input  bp_wb_pkg::bp_mem_size_e                mem_cmd_size_i,
   input  wire [bp_wb_pkg::paddr_width_lp-1:0]    mem_cmd_addr_i,
   input  wire [bp_wb_pkg::dword_width_lp-1:0]    mem_cmd_data_i,
   input  wire                                    mem_cmd_v_i,
   output logic                                   mem_cmd_ready_o,
   output bp_wb_pkg::bp_mem_msg_e                 mem_resp_type_o,
   output logic [bp_wb_pkg::dword_width_lp-1:0]   mem_resp_data_o,
   output logic                                   mem_resp_err_o,
   output logic                                   mem_resp_v_o,
   input  wire                                    mem_resp_yumi_i,
   output logic [bp_wb_pkg::wb_adr_width_lp-1:0]  wb_adr_o,
   output logic [bp_wb_pkg::dword_width_lp-1:0]   wb_dat_o,
   output logic [bp_wb_pkg::wb_sel_width_lp-1:0]  wb_sel_o,
   output logic                                   wb_we_o,
   output logic                                   wb_cyc_o,
   output logic                                   wb_stb_o,
   input  wire [bp_wb_pkg::dword_width_lp-1:0]    wb_dat_i,
   input  wire                                    wb_ack_i,
   input  wire                                    wb_err_i,
   output logic                                   cfg_done_o
);
   import bp_wb_pkg::*;

   // Muxed command into decode
   bp_mem_msg_e                 cmd_type_li;
   bp_mem_size_e                cmd_size_li;
   logic [paddr_width_lp-1:0]   cmd_addr_li;
   logic [dword_width_lp-1:0]   cmd_data_li;
   logic                        cmd_v_li, cmd_ready_lo;
   // Loader side
   logic [paddr_width_lp-1:0]   cfg_addr_lo;
   logic [dword_width_lp-1:0]   cfg_data_lo;
   logic                        cfg_v_lo, cfg_yumi_lo, cfg_done_lo;
   logic                        cfg_resp_v_li;
   // Result stage response
   logic                        resp_v_lo, resp_yumi_li;
   // Decode to exec
   logic                        dec_v_lo, dec_we_lo, exec_ready_lo;
   logic [wb_adr_width_lp-1:0]  dec_adr_lo;
   logic [wb_sel_width_lp-1:0]  dec_sel_lo;
   logic [dword_width_lp-1:0]   dec_dat_lo;
   bp_mem_size_e                dec_size_lo;
   logic [2:0]                  dec_offset_lo;
   // Exec to result
   logic                        exec_v_lo, exec_we_lo, exec_err_lo, res_busy_lo;
   bp_dword_u                   exec_dat_lo;
   bp_mem_size_e                exec_size_lo;
   logic [2:0]                  exec_offset_lo;

   // Fixed arbitration on the done flag, sources never overlap
   always_comb
   begin
      if (~cfg_done_lo)
      begin
         // Loader only writes whole dwords
         cmd_type_li     = e_mem_wr;
         cmd_size_li     = e_size_8;
         cmd_addr_li     = cfg_addr_lo;
         cmd_data_li     = cfg_data_lo;
         cmd_v_li        = cfg_v_lo;
         mem_cmd_ready_o = 1'b0;
         cfg_resp_v_li   = resp_v_lo;
         mem_resp_v_o    = 1'b0;
         resp_yumi_li    = cfg_yumi_lo;
      end
      else
      begin
         cmd_type_li     = mem_cmd_type_i;
         cmd_size_li     = mem_cmd_size_i;
         cmd_addr_li     = mem_cmd_addr_i;
         cmd_data_li     = mem_cmd_data_i;
         cmd_v_li        = mem_cmd_v_i;
         mem_cmd_ready_o = cmd_ready_lo;
         cfg_resp_v_li   = 1'b0;
         mem_resp_v_o    = resp_v_lo;
         resp_yumi_li    = mem_resp_yumi_i;
      end
   end

   assign cfg_done_o = cfg_done_lo;

   bp_wb_cfg_loader cfg_loader
   (
      .clk_i        (clk_i)
      ,.rst_i       (rst_i)
      ,.cmd_v_o     (cfg_v_lo)
      ,.cmd_addr_o  (cfg_addr_lo)
      ,.cmd_data_o  (cfg_data_lo)
      ,.cmd_ready_i (cmd_ready_lo)
      ,.resp_v_i    (cfg_resp_v_li)
      ,.resp_yumi_o (cfg_yumi_lo)
      ,.done_o      (cfg_done_lo)
   );

   bp_wb_cmd_decode decode
   (
      .clk_i         (clk_i)
      ,.rst_i        (rst_i)
      ,.cmd_type_i   (cmd_type_li)
      ,.cmd_size_i   (cmd_size_li)
      ,.cmd_addr_i   (cmd_addr_li)
      ,.cmd_data_i   (cmd_data_li)
      ,.cmd_v_i      (cmd_v_li)
      ,.cmd_ready_o  (cmd_ready_lo)
      ,.dec_ready_i  (exec_ready_lo)
      ,.dec_v_o      (dec_v_lo)
      ,.dec_we_o     (dec_we_lo)
      ,.dec_adr_o    (dec_adr_lo)
      ,.dec_sel_o    (dec_sel_lo)
      ,.dec_dat_o    (dec_dat_lo)
      ,.dec_size_o   (dec_size_lo)
      ,.dec_offset_o (dec_offset_lo)
   );

   bp_wb_cycle_exec exec
   (
      .clk_i          (clk_i)
      ,.rst_i         (rst_i)
      ,.dec_v_i       (dec_v_lo)
      ,.dec_we_i      (dec_we_lo)
      ,.dec_adr_i     (dec_adr_lo)
      ,.dec_sel_i     (dec_sel_lo)
      ,.dec_dat_i     (dec_dat_lo)
      ,.dec_size_i    (dec_size_lo)
      ,.dec_offset_i  (dec_offset_lo)
      ,.dec_ready_o   (exec_ready_lo)
      ,.res_busy_i    (res_busy_lo)
      ,.wb_adr_o      (wb_adr_o)
      ,.wb_dat_o      (wb_dat_o)
      ,.wb_sel_o      (wb_sel_o)
      ,.wb_we_o       (wb_we_o)
      ,.wb_cyc_o      (wb_cyc_o)
      ,.wb_stb_o      (wb_stb_o)
      ,.wb_dat_i      (wb_dat_i)
      ,.wb_ack_i      (wb_ack_i)
      ,.wb_err_i      (wb_err_i)
      ,.exec_v_o      (exec_v_lo)
      ,.exec_we_o     (exec_we_lo)
      ,.exec_err_o    (exec_err_lo)
      ,.exec_dat_o    (exec_dat_lo)
      ,.exec_size_o   (exec_size_lo)
      ,.exec_offset_o (exec_offset_lo)
   );

   bp_wb_resp_result result
   (
      .clk_i          (clk_i)
      ,.rst_i         (rst_i)
      ,.exec_v_i      (exec_v_lo)
      ,.exec_we_i     (exec_we_lo)
      ,.exec_err_i    (exec_err_lo)
      ,.exec_dat_i    (exec_dat_lo)
      ,.exec_size_i   (exec_size_lo)
      ,.exec_offset_i (exec_offset_lo)
      ,.res_busy_o    (res_busy_lo)
      ,.resp_v_o      (resp_v_lo)
      ,.resp_type_o   (mem_resp_type_o)
      ,.resp_data_o   (mem_resp_data_o)
      ,.resp_err_o    (mem_resp_err_o)
      ,.resp_yumi_i   (resp_yumi_li)
   );

endmodule

`default_nettype wire

// ==== verification/bp_wb_system_tb.sv ====
// Testbench for the memory-command to Wishbone bridge
// Wishbone slave model with random ack delay, back-to-back command
// driver and held-off response checker, all fed from the vector file
`default_nettype none

module bp_wb_system_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import bp_wb_pkg::*;

   // Columns of one vector in the testdata file
   localparam int col_kind = 0;
   localparam int col_type = 1;
   localparam int col_size = 2;
   localparam int col_addr = 3;
   localparam int col_data = 4;
   localparam int col_sel  = 5;
   localparam int col_wdat = 6;
   localparam int col_rdat = 7;
   localparam int col_err  = 8;
   localparam int vec_cols = 9;
   localparam int max_vecs = 64;

   logic                        clk_i;
   logic                        rst_i;
   bp_mem_msg_e                 mem_cmd_type_i;
   bp_mem_size_e                mem_cmd_size_i;
   logic [paddr_width_lp-1:0]   mem_cmd_addr_i;
   logic [dword_width_lp-1:0]   mem_cmd_data_i;
   logic                        mem_cmd_v_i;
   logic                        mem_cmd_ready_o;
   bp_mem_msg_e                 mem_resp_type_o;
   logic [dword_width_lp-1:0]   mem_resp_data_o;
   logic                        mem_resp_err_o;
   logic                        mem_resp_v_o;
   logic                        mem_resp_yumi_i;
   logic [wb_adr_width_lp-1:0]  wb_adr_o;
   logic [dword_width_lp-1:0]   wb_dat_o;
   logic [wb_sel_width_lp-1:0]  wb_sel_o;
   logic                        wb_we_o;
   logic                        wb_cyc_o;
   logic                        wb_stb_o;
   logic [dword_width_lp-1:0]   wb_dat_i;
   logic                        wb_ack_i;
   logic                        wb_err_i;
   logic                        cfg_done_o;

   // Word 0 holds the count and the vectors follow
   logic [63:0] vec_words [1 + vec_cols*max_vecs];
   logic [63:0] memory [64];
   int          n_vec;
   int          wb_count;
   int          stall_cycles;

   bp_wb_system_top dut (.*);

   initial
   begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] state);
      logic [31:0] x;
      x = state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [63:0] vec_field(input int v, input int col);
      return vec_words[1 + v*vec_cols + col];
   endfunction

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped at first failure");
   endtask

   task automatic report_mismatch(input string sig, input logic [63:0] got,
                                  input logic [63:0] exp);
      abort_run($sformatf("ERR t=%0t %s got %h expected %h", $time, sig, got, exp));
   endtask

   task automatic check_wb(input logic [wb_adr_width_lp-1:0] exp_adr,
                           input logic [wb_sel_width_lp-1:0] exp_sel,
                           input logic [dword_width_lp-1:0]  exp_dat,
                           input bp_mem_msg_e                exp_type);
      if (wb_adr_o !== exp_adr)
         report_mismatch("wb_adr_o", 64'(wb_adr_o), 64'(exp_adr));
      if (wb_sel_o !== exp_sel)
         report_mismatch("wb_sel_o", 64'(wb_sel_o), 64'(exp_sel));
      if (wb_we_o !== (exp_type == e_mem_wr))
         report_mismatch("wb_we_o", 64'(wb_we_o), 64'(exp_type));
      // Bus data only matters on writes
      if (exp_type == e_mem_wr && wb_dat_o !== exp_dat)
         report_mismatch("wb_dat_o", wb_dat_o, exp_dat);
   endtask

   task automatic check_resp(input bp_mem_msg_e exp_type,
                             input logic [dword_width_lp-1:0] exp_data,
                             input logic exp_err);
      if (mem_resp_type_o !== exp_type)
         report_mismatch("mem_resp_type_o", 64'(mem_resp_type_o), 64'(exp_type));
      if (mem_resp_data_o !== exp_data)
         report_mismatch("mem_resp_data_o", mem_resp_data_o, exp_data);
      if (mem_resp_err_o !== exp_err)
         report_mismatch("mem_resp_err_o", 64'(mem_resp_err_o), 64'(exp_err));
   endtask

   // Match the cycle to its vector, then ack or err it
   task automatic serve_cycle();
      logic [63:0] addr_f;
      logic [63:0] sel_f;
      logic [63:0] typ_f;
      logic [5:0]  idx;
      if (wb_count >= n_vec)
         abort_run("Wishbone cycle seen with no vector left to match it");
      addr_f = vec_field(wb_count, col_addr);
      sel_f  = vec_field(wb_count, col_sel);
      typ_f  = vec_field(wb_count, col_type);
      check_wb(addr_f[paddr_width_lp-1:3], sel_f[7:0], vec_field(wb_count, col_wdat),
               bp_mem_msg_e'(typ_f[0]));
      idx = wb_adr_o[5:0];
      $display("wb cycle %0d t=%0t adr=%h sel=%h we=%b dat=%h",
               wb_count, $time, wb_adr_o, wb_sel_o, wb_we_o, wb_dat_o);
      if (wb_adr_o[wb_adr_width_lp-1])
      begin
         // Error region leaves memory untouched
         wb_dat_i = 64'hbad0_bad0_bad0_bad0;
         wb_err_i = 1'b1;
      end
      else
      begin
         // Byte lanes land only where select is set
         if (wb_we_o)
            for (int b = 0; b < wb_sel_width_lp; b++)
               if (wb_sel_o[b])
                  memory[idx][b*8 +: 8] = wb_dat_o[b*8 +: 8];
         wb_dat_i = memory[idx];
         wb_ack_i = 1'b1;
      end
      wb_count++;
   endtask

   // Wishbone slave acking after 0 to 3 wait cycles
   initial
   begin : wishbone_slave
      logic [31:0] rng;
      logic        busy;
      int          wait_cycles;
      wb_dat_i    = '0;
      wb_ack_i    = 1'b0;
      wb_err_i    = 1'b0;
      rng         = 32'd57;
      busy        = 1'b0;
      wait_cycles = 0;
      for (int i = 0; i < 64; i++)
         memory[i] = {32'hc0de0000 | 32'(i), 32'h5a5a0000 ^ (32'(i) << 4)};
      forever
      begin
         @(posedge clk_i);
         #2;
         // Classic cycles keep strobe and cycle together
         if (wb_stb_o !== wb_cyc_o)
            abort_run("wb_stb_o does not match wb_cyc_o");
         if (wb_ack_i || wb_err_i)
         begin
            // Master saw the ack at this edge and closed the cycle
            if (wb_cyc_o)
               abort_run("wb_cyc_o stayed high after the cycle was acknowledged");
            wb_ack_i = 1'b0;
            wb_err_i = 1'b0;
            busy     = 1'b0;
         end
         else if (wb_cyc_o && wb_stb_o)
         begin
            if (!busy)
            begin
               busy        = 1'b1;
               rng         = xorshift32(rng);
               wait_cycles = int'(rng % 32'd4);
            end
            if (wait_cycles == 0)
               serve_cycle();
            else
               wait_cycles--;
         end
      end
   end

   // External commands back to back with loader rows skipped
   task automatic send_commands();
      logic [63:0] typ_f;
      logic [63:0] size_f;
      logic [63:0] addr_f;
      logic        accepted;
      for (int v = 0; v < n_vec; v++)
      begin
         if (vec_field(v, col_kind) != 64'd0)
         begin
            typ_f  = vec_field(v, col_type);
            size_f = vec_field(v, col_size);
            addr_f = vec_field(v, col_addr);
            mem_cmd_type_i = bp_mem_msg_e'(typ_f[0]);
            mem_cmd_size_i = bp_mem_size_e'(size_f[1:0]);
            mem_cmd_addr_i = addr_f[paddr_width_lp-1:0];
            mem_cmd_data_i = vec_field(v, col_data);
            mem_cmd_v_i    = 1'b1;
            // Transfer at the next edge once ready is seen
            do
            begin
               accepted = mem_cmd_ready_o;
               if (!accepted)
                  stall_cycles++;
               @(posedge clk_i);
               #2;
            end
            while (!accepted);
         end
      end
      mem_cmd_v_i = 1'b0;
   endtask

   // In-order responses with yumi held off by a random count
   task automatic collect_responses();
      logic [31:0] rng;
      logic [63:0] typ_f;
      logic [63:0] err_f;
      int          hold;
      rng = xorshift32(32'd57);
      for (int v = 0; v < n_vec; v++)
      begin
         if (vec_field(v, col_kind) != 64'd0)
         begin
            rng  = xorshift32(rng);
            hold = int'(rng % 32'd6);
            while (!(mem_resp_v_o && hold == 0))
            begin
               if (mem_resp_v_o)
                  hold--;
               @(posedge clk_i);
               #2;
            end
            typ_f = vec_field(v, col_type);
            err_f = vec_field(v, col_err);
            check_resp(bp_mem_msg_e'(typ_f[0]), vec_field(v, col_rdat), err_f[0]);
            mem_resp_yumi_i = 1'b1;
            @(posedge clk_i);
            #2;
            mem_resp_yumi_i = 1'b0;
         end
      end
   endtask

   task automatic run_watchdog();
      repeat (n_vec*200 + 10) @(posedge clk_i);
      abort_run("Timeout: the vectors did not complete within their cycle budget");
   endtask

   initial
   begin : main_sequence
      int n_cfg;
      mem_cmd_type_i  = e_mem_rd;
      mem_cmd_size_i  = e_size_1;
      mem_cmd_addr_i  = '0;
      mem_cmd_data_i  = '0;
      mem_cmd_v_i     = 1'b0;
      mem_resp_yumi_i = 1'b0;
      rst_i           = 1'b1;
      wb_count        = 0;
      stall_cycles    = 0;
      n_cfg           = 0;
      $readmemh("verification/bp_wb_system_testdata.txt", vec_words);
      n_vec = int'(vec_words[0]);
      if (n_vec < 1 || n_vec > max_vecs)
         abort_run("Testdata file gives no usable vector count");
      for (int v = 0; v < n_vec; v++)
         if (vec_field(v, col_kind) == 64'd0)
            n_cfg++;
      fork
         run_watchdog();
      join_none
      repeat (3) @(posedge clk_i);
      #2;
      rst_i = 1'b0;
      // Loader owns the bridge and the external port stays closed
      while (!cfg_done_o)
      begin
         if (mem_cmd_ready_o)
            abort_run("mem_cmd_ready_o went high before cfg_done_o");
         if (mem_resp_v_o)
            abort_run("mem_resp_v_o went high before cfg_done_o");
         @(posedge clk_i);
         #2;
      end
      if (wb_count != n_cfg)
         abort_run("cfg_done_o rose before all configuration writes were seen");
      fork
         send_commands();
         collect_responses();
      join
      // Nothing may trail the last response
      repeat (6)
      begin
         @(posedge clk_i);
         #2;
         if (mem_resp_v_o || wb_cyc_o)
            abort_run("Extra response or bus cycle after the last vector");
      end
      if (wb_count != n_vec)
         abort_run("Number of Wishbone cycles differs from the number of vectors");
      else if (stall_cycles == 0)
         abort_run("mem_cmd_ready_o never fell under back-to-back commands");
      else
      begin
         $display("Simulation finished: PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== bp_wb_system.f ====
logic/bp_wb_pkg.sv
logic/bp_wb_cmd_decode.sv
logic/bp_wb_cycle_exec.sv
logic/bp_wb_resp_result.sv
logic/bp_wb_cfg_loader.sv
logic/bp_wb_system_top.sv
verification/bp_wb_system_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = bp_wb_system_tb
FILELIST  = bp_wb_system.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(SIM)

clean:
	rm -rf $(OBJDIR)

// ==== verification/bp_wb_system_testdata.txt ====
// Word 0 is the vector count, then one vector per line:
// kind(0 loader,1 port) type(0 rd,1 wr) size addr data exp_sel exp_wb_dat exp_resp_dat exp_err
1e
// Boot configuration writes issued by the loader
0 1 3 0000200000 0000000000000001 ff 0000000000000001 0000000000000000 0
0 1 3 0000200008 0000000080000000 ff 0000000080000000 0000000000000000 0
0 1 3 0000200010 0000000000100000 ff 0000000000100000 0000000000000000 0
0 1 3 0000200018 0000000000000000 ff 0000000000000000 0000000000000000 0
// Write and read back at each size and several offsets
1 1 3 0000001040 0123456789abcdef ff 0123456789abcdef 0000000000000000 0
1 0 3 0000001040 0000000000000000 ff 0000000000000000 0123456789abcdef 0
1 1 0 0000001043 ffffffffffffff5a 08 5a5a5a5a5a5a5a5a 0000000000000000 0
1 0 0 0000001043 0000000000000000 08 0000000000000000 000000000000005a 0
1 0 3 0000001040 0000000000000000 ff 0000000000000000 012345675aabcdef 0
1 1 1 0000001046 123456789abcbeef c0 beefbeefbeefbeef 0000000000000000 0
1 0 1 0000001046 0000000000000000 c0 0000000000000000 000000000000beef 0
1 1 2 0000001054 00000000cafef00d f0 cafef00dcafef00d 0000000000000000 0
1 0 2 0000001054 0000000000000000 f0 0000000000000000 00000000cafef00d 0
1 1 1 0000001052 0000000000007788 0c 7788778877887788 0000000000000000 0
1 0 1 0000001052 0000000000000000 0c 0000000000000000 0000000000007788 0
1 1 2 0000001048 000000000badf00d 0f 0badf00d0badf00d 0000000000000000 0
1 0 2 0000001048 0000000000000000 0f 0000000000000000 000000000badf00d 0
1 1 0 0000001040 0000000000000011 01 1111111111111111 0000000000000000 0
// Narrow writes leave the other lanes alone
1 0 3 0000001040 0000000000000000 ff 0000000000000000 beef45675aabcd11 0
1 0 1 0000001044 0000000000000000 30 0000000000000000 0000000000004567 0
1 0 2 0000001044 0000000000000000 f0 0000000000000000 00000000beef4567 0
// Error region, then a normal read of the aliased dword
1 0 3 8000001040 0000000000000000 ff 0000000000000000 0000000000000000 1
1 1 2 8000001044 0000000012345678 f0 1234567812345678 0000000000000000 1
1 0 3 0000001040 0000000000000000 ff 0000000000000000 beef45675aabcd11 0
// Lane extraction from one dword, issued back to back
1 1 3 0000001058 fedcba9876543210 ff fedcba9876543210 0000000000000000 0
1 0 0 000000105f 0000000000000000 80 0000000000000000 00000000000000fe 0
1 0 0 0000001058 0000000000000000 01 0000000000000000 0000000000000010 0
1 0 1 000000105a 0000000000000000 0c 0000000000000000 0000000000007654 0
1 0 2 000000105c 0000000000000000 f0 0000000000000000 00000000fedcba98 0
1 0 3 0000001058 0000000000000000 ff 0000000000000000 fedcba9876543210 0
